/* include/mcl_defs.svh */
`ifndef MCL_DEFS_SVH
`define MCL_DEFS_SVH

// Memory function select field of the microword
`define MCL_MEMSEL_W 3

// Instruction address-read mode from the dispatch RAM
`define MCL_DRAMA_W 3

// Address section number
`define MCL_SECT_W 6

// Held status word / PC flags
`define MCL_HELD_W 12

// Highest legal section in extended addressing
`define MCL_SECT_LIMIT 6'o37

`endif

/* design/mclPkg.sv */
`include "mcl_defs.svh"

package mclPkg;

  typedef logic [`MCL_DRAMA_W-1:0] dramAT;
  typedef logic [`MCL_SECT_W-1:0]  sectionT;
  typedef logic [`MCL_HELD_W-1:0]  heldWordT;

  // Encoding follows the microcode memory field
  typedef enum logic [`MCL_MEMSEL_W-1:0] {
    memNop      = 3'd0,
    memLoadAr   = 3'd1,
    memLoadArx  = 3'd2,
    memRwCycle  = 3'd3,
    memRpwCycle = 3'd4,
    memWrite    = 3'd5,
    memFetch    = 3'd6,
    memAread    = 3'd7
  } memFuncT;

  typedef struct packed {
    logic valid;
    logic loadAr;
    logic loadArx;
    logic pause;
    logic write;
    logic fetch;
    logic read;
  } cycleFlagsT;

  typedef struct packed {
    logic user;
    logic public;
    logic previous;
    logic extended;
    logic adrErr;
  } vmaCtxT;

  // Address break comparator results and enables
  typedef struct packed {
    logic match;
    logic onFetch;
    logic onRead;
    logic onWrite;
    logic user;
  } brkCmpT;

endpackage

/* design/memCycleDecode.sv */
`timescale 1ns/1ps

module memCycleDecode (
  input  logic               clk,
  input  logic               rstN,
  input  logic               memReq,
  input  mclPkg::memFuncT    memSel,
  input  mclPkg::dramAT      dramA,
  output mclPkg::cycleFlagsT cycleFlags
);

  import mclPkg::*;

  logic       areadLoadAr;
  logic       areadPause;
  logic       areadWrite;
  cycleFlagsT flagsNext;

  // Address-read sub-modes from the instruction dispatch
  always_comb begin
    areadLoadAr = dramA[2];
    areadPause  = (dramA == 3'b111);
    areadWrite  = (dramA == 3'b011) ||
                  (dramA == 3'b110) ||
                  (dramA == 3'b111);
  end

  always_comb begin
    flagsNext       = '0;
    flagsNext.valid = 1'b1;

    unique case (memSel)
      memNop: begin
        // Valid cycle with no memory action
      end
      memLoadAr: begin
        flagsNext.loadAr = 1'b1;
      end
      memLoadArx: begin
        flagsNext.loadArx = 1'b1;
      end
      memRwCycle: begin
        flagsNext.loadAr = 1'b1;
        flagsNext.write  = 1'b1;
      end
      memRpwCycle: begin
        flagsNext.loadAr = 1'b1;
        flagsNext.pause  = 1'b1;
        flagsNext.write  = 1'b1;
      end
      memWrite: begin
        flagsNext.write = 1'b1;
      end
      memFetch: begin
        flagsNext.loadArx = 1'b1;
        flagsNext.fetch   = 1'b1;
      end
      memAread: begin
        flagsNext.loadAr = areadLoadAr;
        flagsNext.pause  = areadPause;
        flagsNext.write  = areadWrite;
      end
      default: begin
        flagsNext = '0;
      end
    endcase

    // Any operand load implies a read
    flagsNext.read = flagsNext.loadAr | flagsNext.loadArx;
  end

  // Flags hold until the next request
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cycleFlags <= '0;
    end else if (memReq) begin
      cycleFlags <= flagsNext;
    end
  end

endmodule

/* design/vmaContext.sv */
`timescale 1ns/1ps
`include "mcl_defs.svh"

module vmaContext (
  input  logic            clk,
  input  logic            rstN,
  input  logic            loadVma,
  input  logic            prevEn,
  input  logic            procUser,
  input  logic            procPublic,
  input  logic            prevUser,
  input  logic            prevPublic,
  input  logic            longEn,
  input  logic            section0,
  input  mclPkg::sectionT section,
  output mclPkg::vmaCtxT  vmaCtx
);

  import mclPkg::*;

  logic   userSel;
  logic   publicSel;
  logic   extEn;
  logic   sectOver;
  vmaCtxT ctxNext;

  // Previous context replaces the current one for PXCT-style references
  always_comb begin
    if (prevEn) begin
      userSel   = prevUser;
      publicSel = prevPublic;
    end else begin
      userSel   = procUser;
      publicSel = procPublic;
    end
  end

  // Long address only outside section zero
  always_comb begin
    extEn    = longEn & ~section0;
    sectOver = (section > `MCL_SECT_LIMIT);
  end

  always_comb begin
    ctxNext.user     = userSel;
    ctxNext.public   = publicSel;
    ctxNext.previous = prevEn;
    ctxNext.extended = extEn;
    ctxNext.adrErr   = extEn & sectOver;
  end

  // Whole context latched together
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      vmaCtx <= '0;
    end else if (loadVma) begin
      vmaCtx <= ctxNext;
    end
  end

endmodule

/* design/memRequestCombine.sv */
`timescale 1ns/1ps

module memRequestCombine (
  input  logic               clk,
  input  logic               rstN,
  input  logic               memReq,
  input  logic               loadHeld,
  input  logic               selVma,
  input  mclPkg::cycleFlagsT cycleFlags,
  input  mclPkg::vmaCtxT     vmaCtx,
  input  mclPkg::brkCmpT     brkCmp,
  input  mclPkg::heldWordT   pcFlags,
  output logic               mboxReq,
  output logic               pageAdrCond,
  output mclPkg::heldWordT   heldOrPc
);

  import mclPkg::*;

  logic     reqQ;
  logic     brkKind;
  logic     brkUserOk;
  heldWordT heldNext;
  heldWordT heldWord;

  // Request lines up with the freshly decoded flags
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      reqQ <= 1'b0;
    end else begin
      reqQ <= memReq;
    end
  end

  // No MBOX cycle to an illegal section
  assign mboxReq = reqQ & ~vmaCtx.adrErr;

  // Address break
  always_comb begin
    brkKind = (cycleFlags.fetch & brkCmp.onFetch) |
              (cycleFlags.write & brkCmp.onWrite) |
              (cycleFlags.read & ~cycleFlags.fetch & brkCmp.onRead);
    brkUserOk = (vmaCtx.user == brkCmp.user);
    pageAdrCond = brkCmp.match & brkKind & brkUserOk;
  end

  // Bit order as seen by the microcode condition select
  always_comb begin
    heldNext = {cycleFlags.loadAr,
                cycleFlags.loadArx,
                cycleFlags.pause,
                cycleFlags.write,
                vmaCtx.user,
                vmaCtx.public,
                vmaCtx.previous,
                vmaCtx.extended,
                cycleFlags.fetch,
                cycleFlags.read,
                vmaCtx.adrErr,
                cycleFlags.valid};
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      heldWord <= '0;
    end else if (loadHeld) begin
      heldWord <= heldNext;
    end
  end

  assign heldOrPc = selVma ? heldWord : pcFlags;

endmodule

/* design/memControl.sv */
`timescale 1ns/1ps

module memControl (
  input  logic               clk,
  input  logic               rstN,
  input  logic               memReq,
  input  mclPkg::memFuncT    memSel,
  input  mclPkg::dramAT      dramA,
  input  logic               loadVma,
  input  logic               prevEn,
  input  logic               procUser,
  input  logic               procPublic,
  input  logic               prevUser,
  input  logic               prevPublic,
  input  logic               longEn,
  input  logic               section0,
  input  mclPkg::sectionT    section,
  input  logic               loadHeld,
  input  logic               selVma,
  input  mclPkg::brkCmpT     brkCmp,
  input  mclPkg::heldWordT   pcFlags,
  output logic               mboxReq,
  output logic               pageAdrCond,
  output mclPkg::heldWordT   heldOrPc,
  output mclPkg::cycleFlagsT cycleFlags,
  output mclPkg::vmaCtxT     vmaCtx
);

  memCycleDecode i_memCycleDecode (
    .clk        (clk),
    .rstN       (rstN),
    .memReq     (memReq),
    .memSel     (memSel),
    .dramA      (dramA),
    .cycleFlags (cycleFlags)
  );

  vmaContext i_vmaContext (
    .clk        (clk),
    .rstN       (rstN),
    .loadVma    (loadVma),
    .prevEn     (prevEn),
    .procUser   (procUser),
    .procPublic (procPublic),
    .prevUser   (prevUser),
    .prevPublic (prevPublic),
    .longEn     (longEn),
    .section0   (section0),
    .section    (section),
    .vmaCtx     (vmaCtx)
  );

  memRequestCombine i_memRequestCombine (
    .clk         (clk),
    .rstN        (rstN),
    .memReq      (memReq),
    .loadHeld    (loadHeld),
    .selVma      (selVma),
    .cycleFlags  (cycleFlags),
    .vmaCtx      (vmaCtx),
    .brkCmp      (brkCmp),
    .pcFlags     (pcFlags),
    .mboxReq     (mboxReq),
    .pageAdrCond (pageAdrCond),
    .heldOrPc    (heldOrPc)
  );

endmodule

/* verif/memControl_properties.sv */
`timescale 1ns/1ps

module memControlProps (
  input logic               clk,
  input logic               rstN,
  input logic               memReq,
  input logic               loadVma,
  input logic               loadHeld,
  input logic               selVma,
  input logic               mboxReq,
  input logic               pageAdrCond,
  input mclPkg::heldWordT   heldOrPc,
  input mclPkg::cycleFlagsT cycleFlags,
  input mclPkg::vmaCtxT     vmaCtx
);

  int   failCount = 0;
  logic seenMemReq;
  logic seenLoadVma;
  logic seenLoadHeld;

  // First strobe of each kind since reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      seenMemReq   <= 1'b0;
      seenLoadVma  <= 1'b0;
      seenLoadHeld <= 1'b0;
    end else begin
      if (memReq) seenMemReq <= 1'b1;
      if (loadVma) seenLoadVma <= 1'b1;
      if (loadHeld) seenLoadHeld <= 1'b1;
    end
  end

  // MBOX request one cycle after memReq unless the section is illegal
  reqFollows: assert property (@(posedge clk) disable iff (!rstN)
    memReq |=> (mboxReq == !vmaCtx.adrErr))
    else begin
      failCount++;
      $error("mboxReq missing or wrong after memReq");
    end

  noSpuriousReq: assert property (@(posedge clk) disable iff (!rstN)
    !memReq |=> !mboxReq)
    else begin
      failCount++;
      $error("mboxReq high without a memReq");
    end

  adrErrBlocks: assert property (@(posedge clk) disable iff (!rstN)
    vmaCtx.adrErr |-> !mboxReq)
    else begin
      failCount++;
      $error("mboxReq high during an address error");
    end

  // Quiet outputs until the first strobe
  flagsIdle: assert property (@(posedge clk) disable iff (!rstN)
    !seenMemReq |-> (cycleFlags == '0 && !mboxReq && !pageAdrCond))
    else begin
      failCount++;
      $error("Decode outputs active before any memReq");
    end

  ctxIdle: assert property (@(posedge clk) disable iff (!rstN)
    !seenLoadVma |-> (vmaCtx == '0))
    else begin
      failCount++;
      $error("Context not zero before any loadVma");
    end

  heldIdle: assert property (@(posedge clk) disable iff (!rstN)
    (selVma && !seenLoadHeld) |-> (heldOrPc == '0))
    else begin
      failCount++;
      $error("Held word not zero before any loadHeld");
    end

endmodule

bind memControl memControlProps i_memControlProps (
  .clk         (clk),
  .rstN        (rstN),
  .memReq      (memReq),
  .loadVma     (loadVma),
  .loadHeld    (loadHeld),
  .selVma      (selVma),
  .mboxReq     (mboxReq),
  .pageAdrCond (pageAdrCond),
  .heldOrPc    (heldOrPc),
  .cycleFlags  (cycleFlags),
  .vmaCtx      (vmaCtx)
);

/* verif/memControlTb.sv */
`timescale 1ns/1ps
`include "mcl_defs.svh"

module memControlTb;

  import mclPkg::*;

  localparam int numCycles     = 1500;
  localparam int timeoutCycles = numCycles + 500;

  logic       clk;
  logic       rstN;
  logic       memReq;
  memFuncT    memSel;
  dramAT      dramA;
  logic       loadVma;
  logic       prevEn;
  logic       procUser;
  logic       procPublic;
  logic       prevUser;
  logic       prevPublic;
  logic       longEn;
  logic       section0;
  sectionT    section;
  logic       loadHeld;
  logic       selVma;
  brkCmpT     brkCmp;
  heldWordT   pcFlags;
  logic       mboxReq;
  logic       pageAdrCond;
  heldWordT   heldOrPc;
  cycleFlagsT cycleFlags;
  vmaCtxT     vmaCtx;

  cycleFlagsT  expFlags;
  vmaCtxT      expCtx;
  heldWordT    expHeld;
  logic        expBrk;
  logic [31:0] lfsrState = 32'hf047;
  logic [31:0] rnd;
  int          errorCount = 0;
  int          totalErrors;
  int          cycleCount;

  memControl i_memControl (.*);

  always #5 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int width, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < width; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  function automatic cycleFlagsT expectedFlags(input memFuncT f, input dramAT a);
    cycleFlagsT e;
    e = '0;
    e.valid = 1'b1;
    if (f == memLoadAr || f == memRwCycle || f == memRpwCycle) e.loadAr = 1'b1;
    if (f == memLoadArx || f == memFetch) e.loadArx = 1'b1;
    if (f == memRpwCycle) e.pause = 1'b1;
    if (f == memRwCycle || f == memRpwCycle || f == memWrite) e.write = 1'b1;
    if (f == memFetch) e.fetch = 1'b1;
    if (f == memAread) begin
      e.loadAr = a[2];
      e.pause  = &a;
      e.write  = (a == 3'o3) || (a[2:1] == 2'b11);
    end
    e.read = e.loadAr || e.loadArx;
    return e;
  endfunction

  // Reference registers
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      expFlags <= '0;
      expCtx   <= '0;
      expHeld  <= '0;
    end else begin
      if (memReq) expFlags <= expectedFlags(memSel, dramA);
      if (loadVma) begin
        expCtx.user     <= prevEn ? prevUser : procUser;
        expCtx.public   <= prevEn ? prevPublic : procPublic;
        expCtx.previous <= prevEn;
        expCtx.extended <= longEn && !section0;
        expCtx.adrErr   <= longEn && !section0 && (section > `MCL_SECT_LIMIT);
      end
      if (loadHeld) begin
        expHeld <= {expFlags.loadAr, expFlags.loadArx, expFlags.pause, expFlags.write,
                    expCtx.user, expCtx.public, expCtx.previous, expCtx.extended,
                    expFlags.fetch, expFlags.read, expCtx.adrErr, expFlags.valid};
      end
    end
  end

  always_comb begin
    expBrk = 1'b0;
    if (brkCmp.match && (expCtx.user == brkCmp.user)) begin
      if (expFlags.fetch && brkCmp.onFetch) expBrk = 1'b1;
      if (expFlags.write && brkCmp.onWrite) expBrk = 1'b1;
      if (expFlags.read && !expFlags.fetch && brkCmp.onRead) expBrk = 1'b1;
    end
  end

  flagsCheck: assert property (@(posedge clk) disable iff (!rstN) cycleFlags == expFlags)
    else begin
      errorCount++;
      $display("ERROR at %0t: cycleFlags %b, expected %b",
               $time, $sampled(cycleFlags), $sampled(expFlags));
    end

  ctxCheck: assert property (@(posedge clk) disable iff (!rstN) vmaCtx == expCtx)
    else begin
      errorCount++;
      $display("ERROR at %0t: vmaCtx %b, expected %b", $time, $sampled(vmaCtx), $sampled(expCtx));
    end

  brkCheck: assert property (@(posedge clk) disable iff (!rstN) pageAdrCond == expBrk)
    else begin
      errorCount++;
      $display("ERROR at %0t: pageAdrCond %b, expected %b",
               $time, $sampled(pageAdrCond), $sampled(expBrk));
    end

  heldCheck: assert property (@(posedge clk) disable iff (!rstN)
    heldOrPc == (selVma ? expHeld : pcFlags))
    else begin
      errorCount++;
      $display("ERROR at %0t: heldOrPc %h with selVma %b, held %h, pcFlags %h", $time,
               $sampled(heldOrPc), $sampled(selVma), $sampled(expHeld), $sampled(pcFlags));
    end

  task automatic driveRandom();
    drawBits(1, rnd);
    memReq = rnd[0];
    drawBits(3, rnd);
    memSel = memFuncT'(rnd[2:0]);
    drawBits(3, rnd);
    dramA = rnd[2:0];
    drawBits(8, rnd);
    {loadVma, prevEn, procUser, procPublic, prevUser, prevPublic, longEn, section0} = rnd[7:0];
    drawBits(6, rnd);
    section = rnd[5:0];
    // Held capture about one cycle in four
    drawBits(2, rnd);
    loadHeld = &rnd[1:0];
    drawBits(1, rnd);
    selVma = rnd[0];
    drawBits(5, rnd);
    brkCmp = brkCmpT'(rnd[4:0]);
    drawBits(12, rnd);
    pcFlags = rnd[11:0];
  endtask

  initial begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: run did not finish within %0d cycles", timeoutCycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    {memReq, loadVma, prevEn, procUser, procPublic, prevUser, prevPublic} = '0;
    {longEn, section0, loadHeld, selVma} = '0;
    memSel = memNop;
    dramA = '0;
    section = '0;
    brkCmp = '0;
    pcFlags = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    repeat (numCycles) begin
      @(negedge clk);
      driveRandom();
    end
    @(negedge clk);
    {memReq, loadVma, loadHeld} = '0;
    repeat (4) @(negedge clk);
    totalErrors = errorCount + i_memControl.i_memControlProps.failCount;
    $display("Summary: %0d model errors, %0d property errors",
             errorCount, i_memControl.i_memControlProps.failCount);
    if (totalErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
design/mclPkg.sv
design/memCycleDecode.sv
design/vmaContext.sv
design/memRequestCombine.sv
design/memControl.sv
verif/memControl_properties.sv
verif/memControlTb.sv
